/* logic/sd_host_pkg.sv */
// sd host write path shared definitions
// register map, status layout, transfer word views and DAT framing nibbles

package sd_host_pkg;

   localparam int reg_addr_w = 12;

   ////////////////////////////////////////
   // register map, byte addresses
   ////////////////////////////////////////
   localparam logic [reg_addr_w-1:0] reg_addr_ctrl       = 12'h000;
   localparam logic [reg_addr_w-1:0] reg_addr_start_addr = 12'h004;
   localparam logic [reg_addr_w-1:0] reg_addr_cmd        = 12'h008;
   localparam logic [reg_addr_w-1:0] reg_addr_status     = 12'h00C;

   // status word layout
   localparam int status_busy_bit      = 0;
   localparam int status_done_bit      = 1;
   localparam int status_cfg_error_bit = 2;
   localparam int status_left_lsb      = 16; // blocks_left in 31:16

   // DAT framing
   localparam logic [3:0] dat_start_nibble = 4'h0;
   localparam logic [3:0] dat_end_nibble   = 4'hF;

   // transfer control fields, block_words sits in the top byte
   typedef struct packed {
      logic [7:0]  block_words; // 1 up to fifo depth
      logic [15:0] block_count;
      logic [7:0]  reserved;
   } xfer_ctrl_t;

   // one register write word, seen as control fields or as a RAM byte address
   typedef union packed {
      xfer_ctrl_t  ctrl;
      logic [31:0] addr;
   } reg_word_u;

endpackage

/* logic/host_regs.sv */
`timescale 1ns/1ps
// host register file
// holds transfer control and start address, detects a legal start,
// counts blocks down and builds the status word

module host_regs #(
   parameter int fifo_depth = 16
) (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               reg_wr_en,
   input  logic [sd_host_pkg::reg_addr_w-1:0] reg_address,
   input  logic [31:0]                        reg_wr_data,
   input  logic                               block_sent,
   output logic [31:0]                        reg_rd_data,
   output logic                               start_pulse,
   output logic [7:0]                         block_words,
   output logic [15:0]                        block_count,
   output logic [31:0]                        start_addr
);
   import sd_host_pkg::*;

   reg_word_u   wr_word;
   xfer_ctrl_t  ctrl_q;
   logic [31:0] addr_q;
   logic        busy_q;
   logic        done_q;
   logic        cfg_error_q;
   logic [15:0] blocks_left_q;
   logic        start_req;
   logic        words_legal;
   logic [31:0] status_word;

   assign wr_word     = reg_wr_data;
   assign start_req   = reg_wr_en && (reg_address == reg_addr_cmd) && reg_wr_data[0];
   assign words_legal = (ctrl_q.block_words != 8'd0) &&
                        (ctrl_q.block_words <= 8'(fifo_depth));

   // config registers, frozen while busy
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ctrl_q <= '0;
         addr_q <= '0;
      end else if (reg_wr_en && !busy_q) begin
         if (reg_address == reg_addr_ctrl)
            ctrl_q <= wr_word.ctrl;
         if (reg_address == reg_addr_start_addr)
            addr_q <= wr_word.addr;
      end
   end

   ////////////////////////////////////////
   // start detection and block countdown
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         start_pulse   <= 1'b0;
         busy_q        <= 1'b0;
         done_q        <= 1'b0;
         cfg_error_q   <= 1'b0;
         blocks_left_q <= '0;
      end else begin
         start_pulse <= 1'b0;
         if (start_req && !busy_q) begin   // start while busy is dropped
            if (words_legal) begin
               start_pulse   <= 1'b1;
               cfg_error_q   <= 1'b0;
               blocks_left_q <= ctrl_q.block_count;
               busy_q        <= (ctrl_q.block_count != 16'd0);
               done_q        <= (ctrl_q.block_count == 16'd0); // empty transfer
            end else begin
               cfg_error_q <= 1'b1;
            end
         end else if (block_sent && busy_q) begin
            blocks_left_q <= blocks_left_q - 16'd1;
            if (blocks_left_q == 16'd1) begin // last block out
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end
         end
      end
   end

   always_comb begin
      status_word                           = '0;
      status_word[status_busy_bit]          = busy_q;
      status_word[status_done_bit]          = done_q;
      status_word[status_cfg_error_bit]     = cfg_error_q;
      status_word[status_left_lsb +: 16]    = blocks_left_q;
   end

   // read mux, cmd reads back as zero
   always_comb begin
      case (reg_address)
         reg_addr_ctrl:       reg_rd_data = ctrl_q;
         reg_addr_start_addr: reg_rd_data = addr_q;
         reg_addr_status:     reg_rd_data = status_word;
         default:             reg_rd_data = '0;
      endcase
   end

   assign block_words = ctrl_q.block_words;
   assign block_count = ctrl_q.block_count;
   assign start_addr  = addr_q;

endmodule

/* logic/adma_fetch.sv */
`timescale 1ns/1ps
// RAM fetch engine
// reads block_words x block_count words over a four-phase req/ack
// handshake and pushes each one into the transmit FIFO

module adma_fetch (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        start_pulse,
   input  logic [7:0]  block_words,
   input  logic [15:0] block_count,
   input  logic [31:0] start_addr,
   input  logic        ram_ack,
   input  logic [31:0] data_from_ram,
   input  logic        fifo_full,
   output logic        ram_req,
   output logic [31:0] ram_address,
   output logic        fifo_wr,
   output logic [31:0] fifo_wdata
);

   localparam logic [1:0] st_idle    = 2'd0;
   localparam logic [1:0] st_request = 2'd1; // req high, waiting on ack
   localparam logic [1:0] st_release = 2'd2; // req low, waiting on ack low

   logic [1:0]  state_q;
   logic [23:0] words_left_q;
   logic        got_ack;

   assign got_ack = (state_q == st_request) && ram_ack;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q      <= st_idle;
         ram_req      <= 1'b0;
         ram_address  <= '0;
         words_left_q <= '0;
         fifo_wr      <= 1'b0;
      end else begin
         fifo_wr <= 1'b0;
         case (state_q)
            st_idle: begin
               if (start_pulse) begin
                  ram_address  <= start_addr;
                  words_left_q <= {16'd0, block_words} * {8'd0, block_count};
                  state_q      <= st_release;
               end
            end
            st_request: begin
               if (ram_ack) begin
                  ram_req      <= 1'b0;
                  fifo_wr      <= 1'b1; // push lands the cycle after ack
                  ram_address  <= ram_address + 32'd4;
                  words_left_q <= words_left_q - 24'd1;
                  state_q      <= st_release;
               end
            end
            st_release: begin
               if (words_left_q == 24'd0) begin
                  state_q <= st_idle;
               end else if (!ram_ack && !fifo_full && !fifo_wr) begin
                  // pending push must show in fifo_full first
                  ram_req <= 1'b1;
                  state_q <= st_request;
               end
            end
            default: state_q <= st_idle;
         endcase
      end
   end

   // data capture on the first ack cycle
   always_ff @(posedge clk) begin
      if (got_ack)
         fifo_wdata <= data_from_ram;
   end

endmodule

/* logic/tx_fifo.sv */
`timescale 1ns/1ps
// transmit word FIFO
// circular buffer with show-ahead read data and a fill level

module tx_fifo #(
   parameter int fifo_depth = 16
) (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic                                 fifo_wr,
   input  logic [31:0]                          fifo_wdata,
   input  logic                                 fifo_rd,
   output logic [31:0]                          fifo_rdata,
   output logic                                 fifo_full,
   output logic [$clog2(fifo_depth + 1) - 1:0]  fifo_level
);

   localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int lvl_w = $clog2(fifo_depth + 1);

   logic [31:0]      mem [fifo_depth];
   logic [ptr_w-1:0] wr_ptr_q;
   logic [ptr_w-1:0] rd_ptr_q;
   logic             do_wr;
   logic             do_rd;

   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
      return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign fifo_full  = (fifo_level == lvl_w'(fifo_depth));
   assign do_wr      = fifo_wr && !fifo_full;          // overflow dropped
   assign do_rd      = fifo_rd && (fifo_level != '0);  // underflow dropped
   assign fifo_rdata = mem[rd_ptr_q];                  // head word

   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr_q] <= fifo_wdata;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         fifo_level <= '0;
      end else begin
         if (do_wr)
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (do_rd)
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         case ({do_wr, do_rd})
            2'b10:   fifo_level <= fifo_level + 1'b1;
            2'b01:   fifo_level <= fifo_level - 1'b1;
            default: fifo_level <= fifo_level;   // both or neither
         endcase
      end
   end

endmodule

/* logic/dat_tx.sv */
`timescale 1ns/1ps
// DAT line block framer
// sends start nibble, data nibbles msb first, one CRC16 per line
// and the end nibble, then holds the bus idle for a short gap

module dat_tx #(
   parameter int fifo_depth = 16
) (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic [7:0]                           block_words,
   input  logic [31:0]                          fifo_rdata,
   input  logic [$clog2(fifo_depth + 1) - 1:0]  fifo_level,
   output logic                                 fifo_rd,
   output logic [3:0]                           data_to_card,
   output logic                                 data_to_card_oe,
   output logic                                 block_sent
);
   import sd_host_pkg::*;

   localparam logic [2:0] st_idle  = 3'd0;
   localparam logic [2:0] st_start = 3'd1;
   localparam logic [2:0] st_data  = 3'd2;
   localparam logic [2:0] st_crc   = 3'd3;
   localparam logic [2:0] st_end   = 3'd4;
   localparam logic [2:0] st_gap   = 3'd5;

   logic [2:0]       state_q;
   logic [31:0]      shift_q;       // word on the bus, top nibble showing
   logic [2:0]       nib_cnt_q;
   logic [7:0]       words_left_q;  // words still to pop in this block
   logic [3:0]       bit_cnt_q;
   logic [3:0][15:0] crc_q;
   logic             load_word;
   logic             send_data;
   logic             block_ready;
   logic [3:0]       next_nib;
   logic [3:0]       crc_msb;

   // serial CRC16, x^16 + x^12 + x^5 + 1
   function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic din);
      logic fb;
      fb = din ^ crc[15];
      return {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
   endfunction

   assign block_ready = (block_words != 8'd0) && (8'(fifo_level) >= block_words);
   assign load_word   = (state_q == st_start) ||
                        ((state_q == st_data) && (nib_cnt_q == 3'd7) && (words_left_q != 8'd0));
   assign send_data   = (state_q == st_start) ||
                        ((state_q == st_data) && !((nib_cnt_q == 3'd7) && (words_left_q == 8'd0)));
   assign next_nib    = load_word ? fifo_rdata[31:28] : shift_q[27:24];
   assign fifo_rd     = load_word;

   always_comb begin
      for (int i = 0; i < 4; i++)
         crc_msb[i] = crc_q[i][15];  // line i carries its own CRC
   end

   always_ff @(posedge clk) begin
      if (load_word)
         shift_q <= fifo_rdata;
      else if (state_q == st_data)
         shift_q <= shift_q << 4;
   end

   ////////////////////////////////////////
   // framing FSM
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q         <= st_idle;
         data_to_card    <= dat_end_nibble;  // bus idles high
         data_to_card_oe <= 1'b0;
         block_sent      <= 1'b0;
         nib_cnt_q       <= '0;
         words_left_q    <= '0;
         bit_cnt_q       <= '0;
         crc_q           <= '0;
      end else begin
         block_sent <= 1'b0;
         case (state_q)
            st_idle: begin
               if (block_ready) begin // whole block already buffered
                  state_q         <= st_start;
                  data_to_card_oe <= 1'b1;
                  data_to_card    <= dat_start_nibble;
                  crc_q           <= '0;
               end
            end
            st_start, st_data: begin
               if (send_data) begin
                  state_q      <= st_data;
                  data_to_card <= next_nib;
                  for (int i = 0; i < 4; i++)
                     crc_q[i] <= crc16_step(crc_q[i], next_nib[i]);
                  nib_cnt_q <= load_word ? 3'd0 : nib_cnt_q + 3'd1;
                  if (load_word)
                     words_left_q <= (state_q == st_start) ? block_words - 8'd1
                                                           : words_left_q - 8'd1;
               end else begin
                  // last nibble done, first CRC bit goes out
                  state_q      <= st_crc;
                  bit_cnt_q    <= '0;
                  data_to_card <= crc_msb;
                  for (int i = 0; i < 4; i++)
                     crc_q[i] <= crc_q[i] << 1;
               end
            end
            st_crc: begin
               if (bit_cnt_q == 4'd15) begin
                  state_q      <= st_end;
                  data_to_card <= dat_end_nibble;
               end else begin
                  bit_cnt_q    <= bit_cnt_q + 4'd1;
                  data_to_card <= crc_msb;
                  for (int i = 0; i < 4; i++)
                     crc_q[i] <= crc_q[i] << 1;
               end
            end
            st_end: begin
               state_q         <= st_gap;
               data_to_card_oe <= 1'b0;
               data_to_card    <= dat_end_nibble;
               block_sent      <= 1'b1;
            end
            st_gap:  state_q <= st_idle;  // gap plus idle gives two quiet cycles
            default: state_q <= st_idle;
         endcase
      end
   end

endmodule

/* logic/sd_write_host.sv */
`timescale 1ns/1ps
// SD host controller write path
// registers, RAM fetch, transmit FIFO and DAT serializer on one clock

module sd_write_host #(
   parameter int fifo_depth = 16
) (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               reg_wr_en,
   input  logic [sd_host_pkg::reg_addr_w-1:0] reg_address,
   input  logic [31:0]                        reg_wr_data,
   input  logic                               ram_ack,
   input  logic [31:0]                        data_from_ram,
   output logic [31:0]                        reg_rd_data,
   output logic                               ram_req,
   output logic [31:0]                        ram_address,
   output logic [3:0]                         data_to_card,
   output logic                               data_to_card_oe
);

   logic                                start_pulse;
   logic [7:0]                          block_words;
   logic [15:0]                         block_count;
   logic [31:0]                         start_addr;
   logic                                block_sent;
   logic                                fifo_wr;
   logic [31:0]                         fifo_wdata;
   logic                                fifo_rd;
   logic [31:0]                         fifo_rdata;
   logic                                fifo_full;
   logic [$clog2(fifo_depth + 1) - 1:0] fifo_level;

   host_regs #(.fifo_depth(fifo_depth)) u_host_regs (
      .clk         (clk),
      .arst_n      (arst_n),
      .reg_wr_en   (reg_wr_en),
      .reg_address (reg_address),
      .reg_wr_data (reg_wr_data),
      .block_sent  (block_sent),
      .reg_rd_data (reg_rd_data),
      .start_pulse (start_pulse),
      .block_words (block_words),
      .block_count (block_count),
      .start_addr  (start_addr)
   );

   adma_fetch u_adma_fetch (
      .clk           (clk),
      .arst_n        (arst_n),
      .start_pulse   (start_pulse),
      .block_words   (block_words),
      .block_count   (block_count),
      .start_addr    (start_addr),
      .ram_ack       (ram_ack),
      .data_from_ram (data_from_ram),
      .fifo_full     (fifo_full),
      .ram_req       (ram_req),
      .ram_address   (ram_address),
      .fifo_wr       (fifo_wr),
      .fifo_wdata    (fifo_wdata)
   );

   tx_fifo #(.fifo_depth(fifo_depth)) u_tx_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .fifo_wr    (fifo_wr),
      .fifo_wdata (fifo_wdata),
      .fifo_rd    (fifo_rd),
      .fifo_rdata (fifo_rdata),
      .fifo_full  (fifo_full),
      .fifo_level (fifo_level)
   );

   dat_tx #(.fifo_depth(fifo_depth)) u_dat_tx (
      .clk             (clk),
      .arst_n          (arst_n),
      .block_words     (block_words),
      .fifo_rdata      (fifo_rdata),
      .fifo_level      (fifo_level),
      .fifo_rd         (fifo_rd),
      .data_to_card    (data_to_card),
      .data_to_card_oe (data_to_card_oe),
      .block_sent      (block_sent)
   );

endmodule

/* test/sd_host_assertions.sv */
`timescale 1ns/1ps
// handshake and FIFO checks for the SD write path
// one checker bound into both the FIFO and the RAM fetch engine

module sd_host_assertions (
   input logic        clk,
   input logic        arst_n,
   input logic        wr_en,
   input logic        rd_en,
   input logic        full,
   input logic        empty,
   input logic        req,
   input logic        ack,
   input logic [31:0] address
);

   ////////////////////////////////////////
   // FIFO side
   ////////////////////////////////////////
   no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n)
      wr_en |-> !full)
      else $error("tx fifo written while full");

   no_read_when_empty: assert property (@(posedge clk) disable iff (!arst_n)
      rd_en |-> !empty)
      else $error("tx fifo read while empty");

   ////////////////////////////////////////
   // four-phase RAM handshake
   ////////////////////////////////////////
   // req may only rise once the fetch engine has seen ack low
   req_rise_after_ack_low: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(req) |-> !$past(ack))
      else $error("ram_req raised while ram_ack high");

   address_stable_in_req: assert property (@(posedge clk) disable iff (!arst_n)
      (req && $past(req)) |-> $stable(address))
      else $error("ram_address moved while ram_req high");

endmodule

bind tx_fifo sd_host_assertions u_fifo_checks (
   .clk     (clk),
   .arst_n  (arst_n),
   .wr_en   (fifo_wr),
   .rd_en   (fifo_rd),
   .full    (fifo_full),
   .empty   (fifo_level == '0),
   .req     (1'b0),
   .ack     (1'b0),
   .address (32'd0)
);

bind adma_fetch sd_host_assertions u_fetch_checks (
   .clk     (clk),
   .arst_n  (arst_n),
   .wr_en   (1'b0),
   .rd_en   (1'b0),
   .full    (1'b0),
   .empty   (1'b0),
   .req     (ram_req),
   .ack     (ram_ack),
   .address (ram_address)
);

/* test/tb_sd_write_host.sv */
`timescale 1ns/1ps
// testbench for the SD host write path
// random transfers from a RAM model, card bus capture, CRC16 model per DAT line

module tb_sd_write_host;
   import sd_host_pkg::*;

   localparam int fifo_depth = 16;
   localparam int ram_words  = 1024;  // indexed by address bits 11:2

   logic        clk;
   logic        arst_n;
   logic        reg_wr_en;
   logic [11:0] reg_address;
   logic [31:0] reg_wr_data;
   logic        ram_ack;
   logic [31:0] data_from_ram;
   logic [31:0] reg_rd_data;
   logic        ram_req;
   logic [31:0] ram_address;
   logic [3:0]  data_to_card;
   logic        data_to_card_oe;

   logic [31:0] ram_mem [ram_words];
   logic [31:0] rand_state;
   logic [31:0] delay_state;
   int          ram_max_delay;
   int          ram_wait;
   logic [3:0]  rx_nib [$];    // nibbles of all blocks in one transfer
   int          rx_lens [$];
   int          cur_len;
   int          idle_run;
   bit          seen_block;
   int          error_count;
   int          check_count;
   bit          aborted;

   sd_write_host #(.fifo_depth(fifo_depth)) u_sd_write_host (
      .clk             (clk),
      .arst_n          (arst_n),
      .reg_wr_en       (reg_wr_en),
      .reg_address     (reg_address),
      .reg_wr_data     (reg_wr_data),
      .ram_ack         (ram_ack),
      .data_from_ram   (data_from_ram),
      .reg_rd_data     (reg_rd_data),
      .ram_req         (ram_req),
      .ram_address     (ram_address),
      .data_to_card    (data_to_card),
      .data_to_card_oe (data_to_card_oe)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // bitwise CRC16 with x^16 + x^12 + x^5 + 1
   function automatic logic [15:0] crc16_update(input logic [15:0] crc, input logic bit_in);
      logic [15:0] nxt;
      nxt = crc << 1;
      if (crc[15] ^ bit_in)
         nxt = nxt ^ 16'h1021;
      return nxt;
   endfunction

   task automatic rand_range(input int lo, input int hi, output int v);
      rand_state = lcg_next(rand_state);
      v = lo + int'(rand_state[31:16]) % (hi - lo + 1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic report_timeout(input string what);
      error_count++;
      aborted = 1'b1;
      $display("timeout while waiting for %s", what);
   endtask

   task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
      @(negedge clk);
      reg_wr_en   = 1'b1;
      reg_address = addr;
      reg_wr_data = data;
      @(negedge clk);
      reg_wr_en   = 1'b0;
      reg_address = reg_addr_status; // status is read between writes
   endtask

   // address held a full cycle before the sample
   task automatic reg_read(input logic [11:0] addr, output logic [31:0] data);
      @(negedge clk);
      reg_address = addr;
      @(negedge clk);
      data        = reg_rd_data;
      reg_address = reg_addr_status;
      @(negedge clk);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // counts cycles with any bus activity
   task automatic watch_quiet(input string name, input int cycles);
      int active;
      active = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (ram_req === 1'b1 || data_to_card_oe === 1'b1)
            active++;
      end
      check_value(name, 32'd0, 32'(active));
   endtask

   task automatic wait_left_change(input logic [15:0] left, input int limit);
      int n;
      n = 0;
      while (reg_rd_data[31:16] == left && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (reg_rd_data[31:16] == left)
         report_timeout($sformatf("blocks_left to drop below %0d", left));
   endtask

   ////////////////////////////////////////
   // four-phase RAM responder
   ////////////////////////////////////////
   initial begin
      ram_ack       = 1'b0;
      data_from_ram = '0;
      ram_wait      = 0;
      delay_state   = ~32'd68702;
      forever begin
         @(negedge clk);
         if (!arst_n) begin
            ram_ack = 1'b0;
         end else if (ram_ack) begin
            if (!ram_req) begin
               ram_ack     = 1'b0;
               delay_state = lcg_next(delay_state);
               ram_wait    = int'(delay_state[31:16]) % (ram_max_delay + 1);
            end
         end else if (ram_req) begin
            if (ram_wait == 0) begin
               ram_ack       = 1'b1;
               data_from_ram = ram_mem[ram_address[11:2]];
            end else begin
               ram_wait--;
            end
         end
      end
   end

   // card bus monitor splits the stream into blocks on oe
   initial begin
      cur_len    = 0;
      idle_run   = 0;
      seen_block = 1'b0;
      forever begin
         @(negedge clk);
         if (data_to_card_oe === 1'b1) begin
            if (cur_len == 0 && seen_block)
               check_value("idle gap before block", 32'd1, 32'(idle_run >= 2));
            rx_nib.push_back(data_to_card);
            cur_len++;
            idle_run = 0;
         end else begin
            if (cur_len != 0) begin
               rx_lens.push_back(cur_len);
               cur_len    = 0;
               seen_block = 1'b1;
            end
            idle_run++;
         end
      end
   end

   ////////////////////////////////////////
   // block compare against the RAM model
   ////////////////////////////////////////
   task automatic check_blocks(input int bw, input int bc, input logic [31:0] addr);
      int               pos;
      int               idx;
      logic [31:0]      exp_word;
      logic [31:0]      rx_word;
      logic [3:0]       nib;
      logic [3:0][15:0] crc;
      logic [3:0][15:0] rx_crc;
      check_value("block count", 32'(bc), 32'(rx_lens.size()));
      if (rx_lens.size() != bc)
         return;
      pos = 0;
      for (int b = 0; b < bc; b++) begin
         check_value($sformatf("block %0d length", b), 32'(8 * bw + 18), 32'(rx_lens[b]));
         if (rx_lens[b] != 8 * bw + 18)
            return;
         check_value($sformatf("block %0d start nibble", b), 32'(dat_start_nibble),
                     32'(rx_nib[pos]));
         pos++;
         crc = '0;
         for (int w = 0; w < bw; w++) begin
            idx      = (int'(addr[11:2]) + b * bw + w) % ram_words;
            exp_word = ram_mem[idx];
            rx_word  = '0;
            for (int k = 0; k < 8; k++) begin
               nib     = exp_word[31 - 4 * k -: 4];   // msb nibble first
               rx_word = {rx_word[27:0], rx_nib[pos]};
               for (int l = 0; l < 4; l++)
                  crc[l] = crc16_update(crc[l], nib[l]);
               pos++;
            end
            check_value($sformatf("block %0d word %0d", b, w), exp_word, rx_word);
         end
         rx_crc = '0;
         for (int k = 0; k < 16; k++) begin
            for (int l = 0; l < 4; l++)
               rx_crc[l] = {rx_crc[l][14:0], rx_nib[pos][l]};
            pos++;
         end
         for (int l = 0; l < 4; l++)
            check_value($sformatf("block %0d crc line %0d", b, l), 32'(crc[l]),
                        32'(rx_crc[l]));
         check_value($sformatf("block %0d end nibble", b), 32'(dat_end_nibble),
                     32'(rx_nib[pos]));
         pos++;
      end
   endtask

   task automatic run_transfer(input int bw, input int bc, input logic [31:0] addr,
                               input bit poke_busy);
      logic [15:0] left;
      logic [31:0] rd;
      rx_nib.delete();
      rx_lens.delete();
      reg_write(reg_addr_ctrl, {8'(bw), 16'(bc), 8'h00});
      reg_write(reg_addr_start_addr, addr);
      reg_read(reg_addr_ctrl, rd);
      check_value("ctrl readback", {8'(bw), 16'(bc), 8'h00}, rd);
      reg_read(reg_addr_start_addr, rd);
      check_value("start_addr readback", addr, rd);
      reg_write(reg_addr_cmd, 32'd1);
      reg_read(reg_addr_status, rd);
      if (bc == 0) begin
         check_value("empty transfer status", 32'h0000_0002, rd);
         watch_quiet("activity on empty transfer", 60);
         return;
      end
      check_value("status after start", {16'(bc), 13'd0, 3'b001}, rd);
      if (poke_busy) begin
         reg_write(reg_addr_ctrl, {8'd3, 16'd9, 8'h00});  // must be ignored
         reg_write(reg_addr_cmd, 32'd1);
         reg_read(reg_addr_ctrl, rd);
         check_value("ctrl frozen while busy", {8'(bw), 16'(bc), 8'h00}, rd);
      end
      left = 16'(bc);
      while (left != 16'd0) begin
         wait_left_change(left, 4000);
         if (aborted)
            return;
         check_value("blocks_left step", 32'(left - 16'd1), 32'(reg_rd_data[31:16]));
         left = left - 16'd1;
         if (left != 16'd0)
            check_value("busy during transfer", 32'd1, 32'(reg_rd_data[0]));
      end
      check_value("status at end", 32'h0000_0002, reg_rd_data);
      idle_cycles(3);  // monitor closes the last block
      check_blocks(bw, bc, addr);
   endtask

   task automatic run_bad_config(input int bw);
      logic [31:0] rd;
      reg_write(reg_addr_ctrl, {8'(bw), 16'd2, 8'h00});
      reg_write(reg_addr_cmd, 32'd1);
      reg_read(reg_addr_status, rd);
      check_value($sformatf("cfg_error for block_words %0d", bw), 32'd1, 32'(rd[2]));
      check_value("busy after bad start", 32'd0, 32'(rd[0]));
      watch_quiet("activity after bad start", 40);
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin
      int bw;
      int bc;
      int a;
      reg_wr_en     = 1'b0;
      reg_address   = reg_addr_status;
      reg_wr_data   = '0;
      arst_n        = 1'b0;
      error_count   = 0;
      check_count   = 0;
      aborted       = 1'b0;
      ram_max_delay = 5;
      rand_state    = 32'd68702;
      for (int i = 0; i < ram_words; i++) begin
         rand_state = lcg_next(rand_state);
         ram_mem[i] = rand_state;
      end
      idle_cycles(16);
      arst_n = 1'b1;
      @(negedge clk);
      check_value("oe after reset", 32'd0, 32'(data_to_card_oe));
      check_value("ram_req after reset", 32'd0, 32'(ram_req));
      check_value("data_to_card after reset", 32'hF, 32'(data_to_card));
      check_value("status after reset", 32'd0, reg_rd_data);

      for (int t = 0; t < 6 && !aborted; t++) begin
         rand_range(1, fifo_depth, bw);
         rand_range(1, 4, bc);
         rand_range(0, ram_words - 1, a);
         run_transfer(bw, bc, 32'(a) << 2, 1'b0);
      end
      if (!aborted)
         run_transfer(4, 0, 32'h100, 1'b0);
      if (!aborted)
         run_bad_config(0);
      if (!aborted)
         run_bad_config(fifo_depth + 1);
      if (!aborted) begin
         rand_range(0, ram_words - 1, a);
         run_transfer(5, 3, 32'(a) << 2, 1'b1);  // start written while busy
      end

      // back-pressure with slow RAM and full-size blocks
      ram_max_delay = 12;
      for (int t = 0; t < 3 && !aborted; t++) begin
         rand_range(12, fifo_depth, bw);
         rand_range(2, 4, bc);
         rand_range(0, ram_words - 1, a);
         run_transfer(bw, bc, 32'(a) << 2, 1'b0);
      end

      $display("checks: %0d  errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

/* sim.f */
logic/sd_host_pkg.sv
logic/host_regs.sv
logic/adma_fetch.sv
logic/tx_fifo.sv
logic/dat_tx.sv
logic/sd_write_host.sv
test/sd_host_assertions.sv
test/tb_sd_write_host.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the SD host write path testbench
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module tb_sd_write_host -Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Test FAILED" sim.log; then
   exit 1
fi
if ! grep -q "Test OK" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0
